/* rtl/core_region_pkg.sv */
/*
  Shared widths and types for the core region data side.
  Addresses with upper twelve bits equal to LOCAL_REGION map to the data RAM.
  Only the low 15 bits of a local address are decoded, so the RAM aliases in that window.
*/
`default_nettype none

package core_region_pkg;

  // upper address bits that select the local data RAM
  localparam logic [11:0] LOCAL_REGION = 12'h001;

  localparam int DATA_RAM_BYTES = 32768;
  localparam int RAM_WIDTH      = 64;
  localparam int RAM_STRB       = RAM_WIDTH / 8;
  localparam int RAM_DEPTH      = DATA_RAM_BYTES / RAM_STRB;

  // core side, 32 bit
  typedef logic [31:0] bus_addr_t;
  typedef logic [31:0] bus_data_t;
  typedef logic [3:0]  bus_be_t;

  // RAM side, 64 bit words
  typedef logic [RAM_WIDTH-1:0]         ram_data_t;
  typedef logic [RAM_STRB-1:0]          ram_be_t;
  typedef logic [$clog2(RAM_DEPTH)-1:0] ram_addr_t;

  // interrupts
  typedef logic [31:0] irq_vec_t;
  typedef logic [4:0]  irq_id_t;

  // source of the next load/store response
  typedef enum logic [0:0] {
    SRC_EXT = 1'b0,
    SRC_RAM = 1'b1
  } lsu_src_e;

endpackage

`default_nettype wire

/* rtl/lsu_router.sv */
/*
  Splits core load/store requests between the local RAM and the external bus.
  Response steering follows the last granted target only. The core must not
  switch targets while an external response is still outstanding.
*/
`timescale 1ns/1ps
`default_nettype none

module lsu_router (
  input  wire                        clk,
  input  wire                        rst_n,

  input  wire                        lsu_req_i,
  input  core_region_pkg::bus_addr_t lsu_addr_i,
  input  wire                        lsu_we_i,
  input  core_region_pkg::bus_be_t   lsu_be_i,
  input  core_region_pkg::bus_data_t lsu_wdata_i,
  output logic                       lsu_gnt_o,
  output logic                       lsu_rvalid_o,
  output core_region_pkg::bus_data_t lsu_rdata_o,

  output logic                       ext_req_o,
  output core_region_pkg::bus_addr_t ext_addr_o,
  output logic                       ext_we_o,
  output core_region_pkg::bus_be_t   ext_be_o,
  output core_region_pkg::bus_data_t ext_wdata_o,
  input  wire                        ext_gnt_i,
  input  wire                        ext_rvalid_i,
  input  core_region_pkg::bus_data_t ext_rdata_i,

  output logic                       ram_req_o,
  input  wire                        ram_gnt_i,
  input  wire                        ram_rvalid_i,
  input  core_region_pkg::bus_data_t ram_rdata_i
);

  logic                      is_local;
  core_region_pkg::lsu_src_e src_d;
  core_region_pkg::lsu_src_e src_q;

  // region decode on the upper twelve bits
  assign is_local  = (lsu_addr_i[31:20] == core_region_pkg::LOCAL_REGION);
  assign ext_req_o = lsu_req_i & ~is_local;
  assign ram_req_o = lsu_req_i &  is_local;

  // request fields go to the bus unchanged
  assign ext_addr_o  = lsu_addr_i;
  assign ext_we_o    = lsu_we_i;
  assign ext_be_o    = lsu_be_i;
  assign ext_wdata_o = lsu_wdata_i;

  always_comb begin
    lsu_gnt_o = 1'b0;
    src_d     = src_q;
    if (ext_req_o) begin
      lsu_gnt_o = ext_gnt_i;
      src_d     = core_region_pkg::SRC_EXT;
    end else if (ram_req_o) begin
      lsu_gnt_o = ram_gnt_i;
      src_d     = core_region_pkg::SRC_RAM;
    end
  end

  // remember where the granted request went
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      src_q <= core_region_pkg::SRC_RAM;
    end else if (lsu_gnt_o) begin
      src_q <= src_d;
    end
  end

  // response back to the core
  assign lsu_rdata_o  = (src_q == core_region_pkg::SRC_EXT) ? ext_rdata_i : ram_rdata_i;
  assign lsu_rvalid_o = ext_rvalid_i | ram_rvalid_i;

endmodule

`default_nettype wire

/* rtl/ram_port_mux.sv */
/*
  Shares the 64-bit data RAM between the memory port and the 32-bit core port.
  The memory port always wins and has no grant. Its read data is the RAM output
  one cycle after the request. Core accesses stall while mem_req_i is high.
*/
`timescale 1ns/1ps
`default_nettype none

module ram_port_mux (
  input  wire                        clk,
  input  wire                        rst_n,

  input  wire                        mem_req_i,
  input  core_region_pkg::ram_addr_t mem_addr_i,
  input  wire                        mem_we_i,
  input  core_region_pkg::ram_be_t   mem_be_i,
  input  core_region_pkg::ram_data_t mem_wdata_i,
  output core_region_pkg::ram_data_t mem_rdata_o,

  input  wire                        core_req_i,
  input  core_region_pkg::bus_addr_t core_addr_i,
  input  wire                        core_we_i,
  input  core_region_pkg::bus_be_t   core_be_i,
  input  core_region_pkg::bus_data_t core_wdata_i,
  output logic                       core_gnt_o,
  output logic                       core_rvalid_o,
  output core_region_pkg::bus_data_t core_rdata_o,

  output logic                       ram_en_o,
  output core_region_pkg::ram_addr_t ram_addr_o,
  output logic                       ram_we_o,
  output core_region_pkg::ram_be_t   ram_be_o,
  output core_region_pkg::ram_data_t ram_wdata_o,
  input  core_region_pkg::ram_data_t ram_rdata_i
);

  core_region_pkg::ram_addr_t core_word;
  logic                       core_lane;
  core_region_pkg::ram_be_t   core_be_wide;
  logic                       lane_q;

  // word index from the byte address, lane bit just below it
  assign core_word = core_addr_i[$clog2(core_region_pkg::DATA_RAM_BYTES)-1:
                                 $clog2(core_region_pkg::RAM_STRB)];
  assign core_lane = core_addr_i[$clog2(core_region_pkg::RAM_STRB)-1];

  // byte enables shifted into the selected half
  assign core_be_wide = core_lane ? {core_be_i, 4'b0000} : {4'b0000, core_be_i};

  assign core_gnt_o = core_req_i & ~mem_req_i;

  always_comb begin
    if (mem_req_i) begin
      ram_en_o    = 1'b1;
      ram_addr_o  = mem_addr_i;
      ram_we_o    = mem_we_i;
      ram_be_o    = mem_be_i;
      ram_wdata_o = mem_wdata_i;
    end else begin
      ram_en_o    = core_req_i;
      ram_addr_o  = core_word;
      ram_we_o    = core_we_i;
      ram_be_o    = core_be_wide;
      // same word on both halves, the enables pick one
      ram_wdata_o = {core_wdata_i, core_wdata_i};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      core_rvalid_o <= 1'b0;
    end else begin
      core_rvalid_o <= core_gnt_o;
    end
  end

  // lane of the access in flight
  always_ff @(posedge clk) begin
    if (core_gnt_o) begin
      lane_q <= core_lane;
    end
  end

  assign core_rdata_o = lane_q ? ram_rdata_i[63:32] : ram_rdata_i[31:0];
  assign mem_rdata_o  = ram_rdata_i;

endmodule

`default_nettype wire

/* rtl/data_ram.sv */
/*
  Synchronous single-port RAM with byte enables.
  Read data is registered on every enabled access and shows the old word on a write.
  Contents are undefined after power-up.
*/
`timescale 1ns/1ps
`default_nettype none

module data_ram (
  input  wire                        clk,
  input  wire                        en_i,
  input  core_region_pkg::ram_addr_t addr_i,
  input  wire                        we_i,
  input  core_region_pkg::ram_be_t   be_i,
  input  core_region_pkg::ram_data_t wdata_i,
  output core_region_pkg::ram_data_t rdata_o
);

  core_region_pkg::ram_data_t mem [core_region_pkg::RAM_DEPTH];

  always_ff @(posedge clk) begin
    if (en_i) begin
      if (we_i) begin
        for (int i = 0; i < core_region_pkg::RAM_STRB; i++) begin
          if (be_i[i]) begin
            mem[addr_i][8*i +: 8] <= wdata_i[8*i +: 8];
          end
        end
      end
      rdata_o <= mem[addr_i];
    end
  end

endmodule

`default_nettype wire

/* rtl/irq_encoder.sv */
/*
  Priority encoder for the interrupt lines. The highest set index wins.
  Index is zero when no line is set.
*/
`timescale 1ns/1ps
`default_nettype none

module irq_encoder (
  input  core_region_pkg::irq_vec_t irq_i,
  output logic                      irq_o,
  output core_region_pkg::irq_id_t  irq_id_o
);

  assign irq_o = |irq_i;

  // later iterations override, so the top index is kept
  always_comb begin
    irq_id_o = '0;
    for (int i = 0; i < $bits(core_region_pkg::irq_vec_t); i++) begin
      if (irq_i[i]) begin
        irq_id_o = core_region_pkg::irq_id_t'(i);
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/core_region.sv */
/*
  Data side of the core region with router, RAM port mux, data RAM and irq encoder.
  The core port, external bus and memory port are plain req/gnt/rvalid strobes.
*/
`timescale 1ns/1ps
`default_nettype none

module core_region (
  input  wire                        clk,
  input  wire                        rst_n,

  input  wire                        lsu_req_i,
  input  core_region_pkg::bus_addr_t lsu_addr_i,
  input  wire                        lsu_we_i,
  input  core_region_pkg::bus_be_t   lsu_be_i,
  input  core_region_pkg::bus_data_t lsu_wdata_i,
  output logic                       lsu_gnt_o,
  output logic                       lsu_rvalid_o,
  output core_region_pkg::bus_data_t lsu_rdata_o,

  output logic                       ext_req_o,
  output core_region_pkg::bus_addr_t ext_addr_o,
  output logic                       ext_we_o,
  output core_region_pkg::bus_be_t   ext_be_o,
  output core_region_pkg::bus_data_t ext_wdata_o,
  input  wire                        ext_gnt_i,
  input  wire                        ext_rvalid_i,
  input  core_region_pkg::bus_data_t ext_rdata_i,

  input  wire                        mem_req_i,
  input  core_region_pkg::ram_addr_t mem_addr_i,
  input  wire                        mem_we_i,
  input  core_region_pkg::ram_be_t   mem_be_i,
  input  core_region_pkg::ram_data_t mem_wdata_i,
  output core_region_pkg::ram_data_t mem_rdata_o,

  input  core_region_pkg::irq_vec_t  irq_i,
  output logic                       irq_o,
  output core_region_pkg::irq_id_t   irq_id_o
);

  // core port of the RAM mux
  logic                       ram_req;
  logic                       ram_gnt;
  logic                       ram_rvalid;
  core_region_pkg::bus_data_t ram_rdata;

  // RAM macro side
  logic                       data_mem_en;
  core_region_pkg::ram_addr_t data_mem_addr;
  logic                       data_mem_we;
  core_region_pkg::ram_be_t   data_mem_be;
  core_region_pkg::ram_data_t data_mem_wdata;
  core_region_pkg::ram_data_t data_mem_rdata;

  lsu_router i_lsu_router (
    .clk          ( clk          ),
    .rst_n        ( rst_n        ),
    .lsu_req_i    ( lsu_req_i    ),
    .lsu_addr_i   ( lsu_addr_i   ),
    .lsu_we_i     ( lsu_we_i     ),
    .lsu_be_i     ( lsu_be_i     ),
    .lsu_wdata_i  ( lsu_wdata_i  ),
    .lsu_gnt_o    ( lsu_gnt_o    ),
    .lsu_rvalid_o ( lsu_rvalid_o ),
    .lsu_rdata_o  ( lsu_rdata_o  ),
    .ext_req_o    ( ext_req_o    ),
    .ext_addr_o   ( ext_addr_o   ),
    .ext_we_o     ( ext_we_o     ),
    .ext_be_o     ( ext_be_o     ),
    .ext_wdata_o  ( ext_wdata_o  ),
    .ext_gnt_i    ( ext_gnt_i    ),
    .ext_rvalid_i ( ext_rvalid_i ),
    .ext_rdata_i  ( ext_rdata_i  ),
    .ram_req_o    ( ram_req      ),
    .ram_gnt_i    ( ram_gnt      ),
    .ram_rvalid_i ( ram_rvalid   ),
    .ram_rdata_i  ( ram_rdata    )
  );

  ram_port_mux i_ram_port_mux (
    .clk           ( clk            ),
    .rst_n         ( rst_n          ),
    .mem_req_i     ( mem_req_i      ),
    .mem_addr_i    ( mem_addr_i     ),
    .mem_we_i      ( mem_we_i       ),
    .mem_be_i      ( mem_be_i       ),
    .mem_wdata_i   ( mem_wdata_i    ),
    .mem_rdata_o   ( mem_rdata_o    ),
    .core_req_i    ( ram_req        ),
    .core_addr_i   ( lsu_addr_i     ),
    .core_we_i     ( lsu_we_i       ),
    .core_be_i     ( lsu_be_i       ),
    .core_wdata_i  ( lsu_wdata_i    ),
    .core_gnt_o    ( ram_gnt        ),
    .core_rvalid_o ( ram_rvalid     ),
    .core_rdata_o  ( ram_rdata      ),
    .ram_en_o      ( data_mem_en    ),
    .ram_addr_o    ( data_mem_addr  ),
    .ram_we_o      ( data_mem_we    ),
    .ram_be_o      ( data_mem_be    ),
    .ram_wdata_o   ( data_mem_wdata ),
    .ram_rdata_i   ( data_mem_rdata )
  );

  data_ram i_data_ram (
    .clk     ( clk            ),
    .en_i    ( data_mem_en    ),
    .addr_i  ( data_mem_addr  ),
    .we_i    ( data_mem_we    ),
    .be_i    ( data_mem_be    ),
    .wdata_i ( data_mem_wdata ),
    .rdata_o ( data_mem_rdata )
  );

  irq_encoder i_irq_encoder (
    .irq_i    ( irq_i    ),
    .irq_o    ( irq_o    ),
    .irq_id_o ( irq_id_o )
  );

endmodule

`default_nettype wire

/* tb/tb_clk_gen.sv */
/*
  Testbench clock and reset source. 10 ns period.
  Reset is held low for 5 cycles and released on a falling edge.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (5) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

/* tb/core_region_assertions.sv */
/*
  Bound checker for core_region. A shadow of the data RAM follows writes on both ports.
  Shadow words read before any write hold no known value, so stimulus writes first.
*/
`timescale 1ns/1ps
`default_nettype none

module core_region_assertions (
  input wire                        clk,
  input wire                        rst_n,
  input wire                        lsu_req_i,
  input core_region_pkg::bus_addr_t lsu_addr_i,
  input wire                        lsu_we_i,
  input core_region_pkg::bus_be_t   lsu_be_i,
  input core_region_pkg::bus_data_t lsu_wdata_i,
  input wire                        lsu_gnt_o,
  input wire                        lsu_rvalid_o,
  input core_region_pkg::bus_data_t lsu_rdata_o,
  input wire                        ext_req_o,
  input core_region_pkg::bus_addr_t ext_addr_o,
  input wire                        ext_we_o,
  input core_region_pkg::bus_be_t   ext_be_o,
  input core_region_pkg::bus_data_t ext_wdata_o,
  input wire                        ext_gnt_i,
  input wire                        ext_rvalid_i,
  input core_region_pkg::bus_data_t ext_rdata_i,
  input wire                        mem_req_i,
  input core_region_pkg::ram_addr_t mem_addr_i,
  input wire                        mem_we_i,
  input core_region_pkg::ram_be_t   mem_be_i,
  input core_region_pkg::ram_data_t mem_wdata_i,
  input core_region_pkg::ram_data_t mem_rdata_o,
  input core_region_pkg::irq_vec_t  irq_i,
  input wire                        irq_o,
  input core_region_pkg::irq_id_t   irq_id_o
);

  core_region_pkg::ram_data_t shadow [core_region_pkg::RAM_DEPTH];
  int unsigned                error_count = 0;
  logic                       is_local;
  core_region_pkg::ram_addr_t core_word;
  logic                       core_lane;
  logic                       core_chk_q;
  core_region_pkg::bus_data_t core_exp_q;
  logic                       mem_chk_q;
  core_region_pkg::ram_data_t mem_exp_q;

  function automatic core_region_pkg::irq_id_t top_irq(core_region_pkg::irq_vec_t v);
    core_region_pkg::irq_id_t id;
    logic                     found;
    id    = '0;
    found = 1'b0;
    for (int i = 31; i >= 0; i--) begin
      if (v[i] && !found) begin
        id    = core_region_pkg::irq_id_t'(i);
        found = 1'b1;
      end
    end
    return id;
  endfunction

  assign is_local  = (lsu_addr_i[31:20] == core_region_pkg::LOCAL_REGION);
  assign core_word = lsu_addr_i[14:3];
  assign core_lane = lsu_addr_i[2];

  // shadow keeps the word as it stands after each edge
  always_ff @(posedge clk) begin
    if (mem_req_i && mem_we_i) begin
      for (int b = 0; b < 8; b++) begin
        if (mem_be_i[b]) shadow[mem_addr_i][8*b +: 8] <= mem_wdata_i[8*b +: 8];
      end
    end else if (lsu_gnt_o && is_local && lsu_we_i) begin
      for (int b = 0; b < 4; b++) begin
        if (lsu_be_i[b]) shadow[core_word][32*core_lane + 8*b +: 8] <= lsu_wdata_i[8*b +: 8];
      end
    end
  end

  // expected read data, due one cycle after the access
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      core_chk_q <= 1'b0;
      mem_chk_q  <= 1'b0;
    end else begin
      core_chk_q <= lsu_gnt_o && is_local && !lsu_we_i;
      core_exp_q <= core_lane ? shadow[core_word][63:32] : shadow[core_word][31:0];
      mem_chk_q  <= mem_req_i && !mem_we_i;
      mem_exp_q  <= shadow[mem_addr_i];
    end
  end

  a_reset_rvalid: assert property (@(posedge clk) $rose(rst_n) |-> !lsu_rvalid_o)
    else begin $error("[ERROR] %0t rvalid high after reset", $time); error_count++; end
  a_ext_idle: assert property (@(posedge clk) disable iff (!rst_n) !lsu_req_i |-> !ext_req_o)
    else begin $error("[ERROR] %0t ext_req_o without request", $time); error_count++; end
  a_local_rvalid: assert property (@(posedge clk) disable iff (!rst_n)
    (lsu_gnt_o && is_local) |=> lsu_rvalid_o)
    else begin $error("[ERROR] %0t no rvalid after local grant", $time); error_count++; end
  a_no_early_rvalid: assert property (@(posedge clk) disable iff (!rst_n)
    (lsu_rvalid_o && !ext_rvalid_i) |-> $past(lsu_gnt_o && is_local))
    else begin $error("[ERROR] %0t rvalid without grant", $time); error_count++; end
  a_core_rdata: assert property (@(posedge clk) disable iff (!rst_n)
    core_chk_q |-> (lsu_rdata_o == core_exp_q))
    else begin $error("[ERROR] %0t core read data mismatch", $time); error_count++; end
  a_mem_rdata: assert property (@(posedge clk) disable iff (!rst_n)
    mem_chk_q |-> (mem_rdata_o == mem_exp_q))
    else begin $error("[ERROR] %0t memory read data mismatch", $time); error_count++; end
  a_mem_priority: assert property (@(posedge clk) disable iff (!rst_n)
    (mem_req_i && lsu_req_i && is_local) |-> !lsu_gnt_o)
    else begin $error("[ERROR] %0t core granted over memory port", $time); error_count++; end
  a_ext_req: assert property (@(posedge clk) disable iff (!rst_n)
    ext_req_o == (lsu_req_i && !is_local))
    else begin $error("[ERROR] %0t wrong ext_req_o routing", $time); error_count++; end
  a_ext_fields: assert property (@(posedge clk) disable iff (!rst_n)
    ext_req_o |-> (ext_addr_o == lsu_addr_i && ext_we_o == lsu_we_i &&
                   ext_be_o == lsu_be_i && ext_wdata_o == lsu_wdata_i && lsu_gnt_o == ext_gnt_i))
    else begin $error("[ERROR] %0t ext fields or grant differ", $time); error_count++; end
  a_ext_rdata: assert property (@(posedge clk) disable iff (!rst_n)
    ext_rvalid_i |-> (lsu_rvalid_o && lsu_rdata_o == ext_rdata_i))
    else begin $error("[ERROR] %0t ext read data not forwarded", $time); error_count++; end
  a_irq: assert property (@(posedge clk) disable iff (!rst_n)
    (irq_o == (irq_i != '0)) && (irq_id_o == top_irq(irq_i)))
    else begin $error("[ERROR] %0t wrong interrupt encoding", $time); error_count++; end

endmodule

`default_nettype wire

/* tb/core_region_tb.sv */
/*
  Testbench for core_region. Checking is done by the bound assertion module.
  Local traffic uses the first 16 RAM words only, all written before any read.
*/
`timescale 1ns/1ps
`default_nettype none

module core_region_tb;

  localparam int N_LOCAL = 200;
  localparam int N_EXT   = 60;
  localparam int N_IRQ   = 60;
  // worst case cycles per operation, doubled for margin
  localparam int TIMEOUT_CYCLES = 2 * (40 + 3 * N_LOCAL + 8 * N_EXT + N_IRQ);

  logic                       clk;
  logic                       rst_n;
  logic                       lsu_req_i;
  core_region_pkg::bus_addr_t lsu_addr_i;
  logic                       lsu_we_i;
  core_region_pkg::bus_be_t   lsu_be_i;
  core_region_pkg::bus_data_t lsu_wdata_i;
  logic                       lsu_gnt_o;
  logic                       lsu_rvalid_o;
  core_region_pkg::bus_data_t lsu_rdata_o;
  logic                       ext_req_o;
  core_region_pkg::bus_addr_t ext_addr_o;
  logic                       ext_we_o;
  core_region_pkg::bus_be_t   ext_be_o;
  core_region_pkg::bus_data_t ext_wdata_o;
  logic                       ext_gnt_i;
  logic                       ext_rvalid_i;
  core_region_pkg::bus_data_t ext_rdata_i;
  logic                       mem_req_i;
  core_region_pkg::ram_addr_t mem_addr_i;
  logic                       mem_we_i;
  core_region_pkg::ram_be_t   mem_be_i;
  core_region_pkg::ram_data_t mem_wdata_i;
  core_region_pkg::ram_data_t mem_rdata_o;
  core_region_pkg::irq_vec_t  irq_i;
  logic                       irq_o;
  core_region_pkg::irq_id_t   irq_id_o;
  logic                       traffic_on;
  int                         cycles;

  bind core_region core_region_assertions i_checks (.*);

  tb_clk_gen i_clk_gen (.clk_o(clk), .rst_no(rst_n));

  core_region i_core_region (.*);

  function automatic core_region_pkg::bus_addr_t local_addr(int word, int lane);
    return core_region_pkg::bus_addr_t'(32'h0010_0000 | (word << 3) | (lane << 2));
  endfunction

  // one memory port access, held for a single cycle
  task automatic mem_access(input logic we, input int word, input core_region_pkg::ram_be_t be);
    @(negedge clk);
    mem_req_i   = 1'b1;
    mem_we_i    = we;
    mem_addr_i  = core_region_pkg::ram_addr_t'(word);
    mem_be_i    = be;
    mem_wdata_i = {$urandom, $urandom};
    @(negedge clk);
    mem_req_i = 1'b0;
  endtask

  // core access, answered by the bus model when the address is not local
  task automatic core_access(input core_region_pkg::bus_addr_t addr, input logic we);
    logic granted;
    @(negedge clk);
    lsu_req_i   = 1'b1;
    lsu_addr_i  = addr;
    lsu_we_i    = we;
    lsu_be_i    = core_region_pkg::bus_be_t'($urandom);
    lsu_wdata_i = $urandom;
    ext_gnt_i   = 1'($urandom_range(0, 1));
    do begin
      @(posedge clk);
      granted = lsu_gnt_o;
      @(negedge clk);
      if (!granted) ext_gnt_i = 1'($urandom_range(0, 1));
    end while (!granted);
    lsu_req_i = 1'b0;
    ext_gnt_i = 1'b0;
    if (addr[31:20] != core_region_pkg::LOCAL_REGION) begin
      repeat ($urandom_range(0, 3)) @(negedge clk);
      ext_rvalid_i = 1'b1;
      ext_rdata_i  = $urandom;
      @(negedge clk);
      ext_rvalid_i = 1'b0;
    end
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Test failures found");
      $fatal(1, "timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    end
  end

  always @(negedge clk) begin
    if (i_core_region.i_checks.error_count != 0) begin
      $display("Test failures found");
      $fatal(1, "an assertion on the DUT failed");
    end
  end

  initial begin
    void'($urandom(91812));
    cycles       = 0;
    traffic_on   = 1'b0;
    lsu_req_i    = 1'b0;
    lsu_addr_i   = '0;
    lsu_we_i     = 1'b0;
    lsu_be_i     = '0;
    lsu_wdata_i  = '0;
    ext_gnt_i    = 1'b0;
    ext_rvalid_i = 1'b0;
    ext_rdata_i  = '0;
    mem_req_i    = 1'b0;
    mem_addr_i   = '0;
    mem_we_i     = 1'b0;
    mem_be_i     = '0;
    mem_wdata_i  = '0;
    irq_i        = '0;
    @(posedge rst_n);
    repeat (3) @(negedge clk);

    // fill the test window through the memory port
    for (int w = 0; w < 16; w++) mem_access(1'b1, w, 8'hff);

    // random local traffic with memory port accesses alongside
    traffic_on = 1'b1;
    fork
      begin
        for (int i = 0; i < N_LOCAL; i++) begin
          core_access(local_addr($urandom_range(0, 15), $urandom_range(0, 1)),
                      1'($urandom_range(0, 1)));
        end
        traffic_on = 1'b0;
      end
      begin
        while (traffic_on) begin
          @(negedge clk);
          if (traffic_on) begin
            mem_req_i   = ($urandom_range(0, 3) == 0);
            mem_we_i    = 1'($urandom_range(0, 1));
            mem_addr_i  = core_region_pkg::ram_addr_t'($urandom_range(0, 15));
            mem_be_i    = core_region_pkg::ram_be_t'($urandom);
            mem_wdata_i = {$urandom, $urandom};
          end
        end
        mem_req_i = 1'b0;
      end
    join

    // memory port word seen in both core lanes, then read back
    mem_access(1'b1, 5, 8'hff);
    core_access(local_addr(5, 0), 1'b0);
    core_access(local_addr(5, 1), 1'b0);
    mem_access(1'b0, 5, 8'h00);

    // external bus, with a few local accesses mixed in
    for (int i = 0; i < N_EXT; i++) begin
      if ($urandom_range(0, 4) == 0) begin
        core_access(local_addr($urandom_range(0, 15), 0), 1'b0);
      end else begin
        core_access({12'h200, 20'($urandom)}, 1'($urandom_range(0, 1)));
      end
    end

    for (int i = 0; i < N_IRQ; i++) begin
      @(negedge clk);
      irq_i = core_region_pkg::irq_vec_t'($urandom >> $urandom_range(0, 31));
    end
    @(negedge clk);
    irq_i = '0;
    repeat (3) @(negedge clk);

    if (i_core_region.i_checks.error_count == 0) begin
      $display("All tests passed!");
      $finish;
    end else begin
      $display("Test failures found");
      $fatal(1, "assertion failures were recorded");
    end
  end

endmodule

`default_nettype wire

/* core_region.f */
rtl/core_region_pkg.sv
rtl/lsu_router.sv
rtl/ram_port_mux.sv
rtl/data_ram.sv
rtl/irq_encoder.sv
rtl/core_region.sv
tb/tb_clk_gen.sv
tb/core_region_assertions.sv
tb/core_region_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --assert --timing -f core_region.f --top-module core_region_tb -Mdir obj_dir
	./obj_dir/Vcore_region_tb +verilator+error+limit+100

clean:
	rm -rf obj_dir
